/* hw/boot_cfg_pkg.sv */
package boot_cfg_pkg;

   // data word of memory and config space
   localparam int DATA_W = 32;

   // word address into memory
   localparam int ADDR_W = 16;

   // config register index
   localparam int CFG_REG_W = 8;

   // core id carried in config space
   localparam int CORE_ID_W = 4;

   // command payload, wide enough for addr + data
   localparam int PAYLOAD_W = 48;

   // opcode
   localparam int OP_W = 2;

endpackage

/* hw/boot_msg_pkg.sv */
package boot_msg_pkg;

   // command opcodes
   localparam logic [boot_cfg_pkg::OP_W-1:0] OP_MEM_WR = 2'd1;
   localparam logic [boot_cfg_pkg::OP_W-1:0] OP_CFG_WR = 2'd2;

   // config register indices
   localparam logic [boot_cfg_pkg::CFG_REG_W-1:0] CFG_FREEZE  = 8'h01;
   localparam logic [boot_cfg_pkg::CFG_REG_W-1:0] CFG_CORE_ID = 8'h02;

   // one payload word, view picked by opcode
   typedef union packed
   {
      struct packed
      {
         logic [boot_cfg_pkg::ADDR_W-1:0] addr;
         logic [boot_cfg_pkg::DATA_W-1:0] data;
      } mem;
      struct packed
      {
         logic [boot_cfg_pkg::CFG_REG_W-1:0] reg_idx;
         logic [boot_cfg_pkg::PAYLOAD_W-boot_cfg_pkg::CFG_REG_W
                -boot_cfg_pkg::DATA_W-1:0] pad;
         logic [boot_cfg_pkg::DATA_W-1:0] value;
      } cfg;
   } boot_payload_u;

endpackage

/* hw/boot_cmd_sequencer.sv */
`timescale 1ns/1ps

module boot_cmd_sequencer
  #(parameter int fifo_depth_p = 4
   ,parameter int img_base_p = 256
   )
   (input  logic                                  clk_i
   ,input  logic                                  rst_i

   ,input  logic [boot_cfg_pkg::CORE_ID_W-1:0]    core_id_i

   ,input  logic                                  img_v_i
   ,input  logic [boot_cfg_pkg::DATA_W-1:0]       img_data_i
   ,input  logic                                  img_last_i
   ,output logic                                  img_ready_o

   ,output logic                                  cmd_v_o
   ,output logic [boot_cfg_pkg::OP_W-1:0]         cmd_op_o
   ,output boot_msg_pkg::boot_payload_u           cmd_payload_o
   ,input  logic                                  cmd_ready_i

   ,input  logic                                  resp_v_i
   ,input  logic [boot_cfg_pkg::OP_W-1:0]         resp_op_i
   ,output logic                                  resp_ready_o

   ,output logic                                  done_o
   );

   import boot_cfg_pkg::*;
   import boot_msg_pkg::*;

   // phases
   localparam logic [2:0] S_CFG_FREEZE = 3'd0;
   localparam logic [2:0] S_CFG_CORE   = 3'd1;
   localparam logic [2:0] S_IMAGE      = 3'd2;
   localparam logic [2:0] S_UNFREEZE   = 3'd3;
   localparam logic [2:0] S_DRAIN      = 3'd4;
   localparam logic [2:0] S_DONE       = 3'd5;

   // fifo entries + held response + pending command
   localparam int cnt_w_lp = $clog2(fifo_depth_p + 3) + 1;

   logic [2:0]            state_r;
   logic                  cmd_v_r;
   logic [OP_W-1:0]       cmd_op_r;
   boot_payload_u         cmd_payload_r;
   logic [ADDR_W-1:0]     img_idx_r;
   logic [cnt_w_lp-1:0]   outstanding_r;
   logic [1:0]            cfg_acks_r;

   logic                  push;
   logic                  retire;
   logic                  img_fire;
   logic                  slot_free;
   logic                  load;
   logic [OP_W-1:0]       load_op;
   boot_payload_u         load_payload;

   assign push      = cmd_v_r & cmd_ready_i;
   assign retire    = resp_v_i & resp_ready_o;
   assign slot_free = ~cmd_v_r | push;

   // no new word while a command still waits for the fifo
   assign img_ready_o = (state_r == S_IMAGE) & ~cmd_v_r;
   assign img_fire    = img_v_i & img_ready_o;

   always_comb
   begin
      load         = 1'b0;
      load_op      = OP_CFG_WR;
      load_payload = '0;
      case (state_r)
         S_CFG_FREEZE:
         begin
            load                       = slot_free;
            load_payload.cfg.reg_idx   = CFG_FREEZE;
            load_payload.cfg.value     = DATA_W'(1);
         end
         S_CFG_CORE:
         begin
            load                       = slot_free;
            load_payload.cfg.reg_idx   = CFG_CORE_ID;
            load_payload.cfg.value     = {{(DATA_W-CORE_ID_W){1'b0}}, core_id_i};
         end
         S_IMAGE:
         begin
            load                       = img_fire;
            load_op                    = OP_MEM_WR;
            load_payload.mem.addr      = ADDR_W'(img_base_p) + img_idx_r;
            load_payload.mem.data      = img_data_i;
         end
         S_UNFREEZE:
         begin
            // release the core
            load                       = slot_free;
            load_payload.cfg.reg_idx   = CFG_FREEZE;
         end
         default:
         begin
         end
      endcase
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         state_r       <= S_CFG_FREEZE;
         cmd_v_r       <= 1'b0;
         img_idx_r     <= '0;
         outstanding_r <= '0;
         cfg_acks_r    <= '0;
      end
      else
      begin
         if (load)
            cmd_v_r <= 1'b1;
         else if (push)
            cmd_v_r <= 1'b0;

         case ({push, retire})
            2'b10:   outstanding_r <= outstanding_r + 1'b1;
            2'b01:   outstanding_r <= outstanding_r - 1'b1;
            default: outstanding_r <= outstanding_r;
         endcase

         if (retire && resp_op_i == OP_CFG_WR && cfg_acks_r != 2'd3)
            cfg_acks_r <= cfg_acks_r + 1'b1;

         if (img_fire)
            img_idx_r <= img_idx_r + 1'b1;

         case (state_r)
            S_CFG_FREEZE: if (load) state_r <= S_CFG_CORE;
            S_CFG_CORE:   if (load) state_r <= S_IMAGE;
            S_IMAGE:      if (img_fire && img_last_i) state_r <= S_UNFREEZE;
            S_UNFREEZE:   if (load) state_r <= S_DRAIN;
            // all three config writes acked and nothing in flight
            S_DRAIN:
               if (!cmd_v_r && outstanding_r == '0 && cfg_acks_r == 2'd3)
                  state_r <= S_DONE;
            default:      state_r <= state_r;
         endcase
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (load)
      begin
         cmd_op_r      <= load_op;
         cmd_payload_r <= load_payload;
      end
   end

   assign cmd_v_o       = cmd_v_r;
   assign cmd_op_o      = cmd_op_r;
   assign cmd_payload_o = cmd_payload_r;

   // responses are always taken
   assign resp_ready_o  = 1'b1;

   assign done_o        = (state_r == S_DONE);

endmodule

/* hw/boot_cmd_fifo.sv */
`timescale 1ns/1ps

module boot_cmd_fifo
  #(parameter int fifo_depth_p = 4
   ,parameter int depth_p = fifo_depth_p
   )
   (input  logic                              clk_i
   ,input  logic                              rst_i

   ,input  logic                              v_i
   ,input  logic [boot_cfg_pkg::OP_W-1:0]     op_i
   ,input  boot_msg_pkg::boot_payload_u       payload_i
   ,output logic                              ready_o

   ,output logic                              v_o
   ,output logic [boot_cfg_pkg::OP_W-1:0]     op_o
   ,output boot_msg_pkg::boot_payload_u       payload_o
   ,input  logic                              yumi_i
   );

   import boot_cfg_pkg::*;
   import boot_msg_pkg::*;

   localparam int ptr_w_lp = $clog2(depth_p);

   logic [OP_W-1:0]     op_mem_r      [depth_p];
   boot_payload_u       payload_mem_r [depth_p];
   logic [ptr_w_lp-1:0] wr_ptr_r;
   logic [ptr_w_lp-1:0] rd_ptr_r;
   logic [ptr_w_lp:0]   count_r;
   logic                push;

   assign ready_o = (count_r != (ptr_w_lp+1)'(depth_p));
   assign v_o     = (count_r != '0);
   assign push    = v_i & ready_o;

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         wr_ptr_r <= '0;
         rd_ptr_r <= '0;
         count_r  <= '0;
      end
      else
      begin
         // pointers wrap on the power-of-two depth
         if (push)
            wr_ptr_r <= wr_ptr_r + 1'b1;
         if (yumi_i)
            rd_ptr_r <= rd_ptr_r + 1'b1;
         if (push && !yumi_i)
            count_r <= count_r + 1'b1;
         else if (!push && yumi_i)
            count_r <= count_r - 1'b1;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (push)
      begin
         op_mem_r[wr_ptr_r]      <= op_i;
         payload_mem_r[wr_ptr_r] <= payload_i;
      end
   end

   // oldest entry
   assign op_o      = op_mem_r[rd_ptr_r];
   assign payload_o = payload_mem_r[rd_ptr_r];

endmodule

/* hw/boot_mem_target.sv */
`timescale 1ns/1ps

module boot_mem_target
  #(parameter int mem_words_p = 1024
   )
   (input  logic                                  clk_i
   ,input  logic                                  rst_i

   ,input  logic                                  cmd_v_i
   ,input  logic [boot_cfg_pkg::OP_W-1:0]         cmd_op_i
   ,input  boot_msg_pkg::boot_payload_u           cmd_payload_i
   ,output logic                                  cmd_yumi_o

   ,output logic                                  resp_v_o
   ,output logic [boot_cfg_pkg::OP_W-1:0]         resp_op_o
   ,input  logic                                  resp_ready_i

   ,input  logic                                  mem_rd_v_i
   ,input  logic [boot_cfg_pkg::ADDR_W-1:0]       mem_rd_addr_i
   ,output logic [boot_cfg_pkg::DATA_W-1:0]       mem_rd_data_o

   ,output logic                                  freeze_o
   ,output logic [boot_cfg_pkg::CORE_ID_W-1:0]    core_id_o
   );

   import boot_cfg_pkg::*;
   import boot_msg_pkg::*;

   localparam int mem_aw_lp = $clog2(mem_words_p);

   logic [DATA_W-1:0]    mem_r [mem_words_p];
   logic [DATA_W-1:0]    rd_data_r;
   logic                 resp_v_r;
   logic [OP_W-1:0]      resp_op_r;
   logic                 freeze_r;
   logic [CORE_ID_W-1:0] core_id_r;

   logic                 mem_wr;
   logic                 cfg_wr;

   // take a command only with the response slot empty
   assign cmd_yumi_o = cmd_v_i & ~resp_v_r;

   assign mem_wr = cmd_yumi_o & (cmd_op_i == OP_MEM_WR);
   assign cfg_wr = cmd_yumi_o & (cmd_op_i == OP_CFG_WR);

   always_ff @(posedge clk_i)
   begin
      if (mem_wr)
         mem_r[cmd_payload_i.mem.addr[mem_aw_lp-1:0]] <= cmd_payload_i.mem.data;
      if (mem_rd_v_i)
         rd_data_r <= mem_r[mem_rd_addr_i[mem_aw_lp-1:0]];
   end

   assign mem_rd_data_o = rd_data_r;

   // config registers, core starts frozen
   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         freeze_r  <= 1'b1;
         core_id_r <= '0;
      end
      else if (cfg_wr)
      begin
         case (cmd_payload_i.cfg.reg_idx)
            CFG_FREEZE:  freeze_r  <= cmd_payload_i.cfg.value[0];
            CFG_CORE_ID: core_id_r <= cmd_payload_i.cfg.value[CORE_ID_W-1:0];
            default:     core_id_r <= core_id_r;
         endcase
      end
   end

   assign freeze_o  = freeze_r;
   assign core_id_o = core_id_r;

   // held until the sequencer accepts it
   always_ff @(posedge clk_i)
   begin
      if (rst_i)
         resp_v_r <= 1'b0;
      else if (cmd_yumi_o)
         resp_v_r <= 1'b1;
      else if (resp_ready_i)
         resp_v_r <= 1'b0;
   end

   always_ff @(posedge clk_i)
   begin
      if (cmd_yumi_o)
         resp_op_r <= cmd_op_i;
   end

   assign resp_v_o  = resp_v_r;
   assign resp_op_o = resp_op_r;

endmodule

/* hw/boot_loader_top.sv */
`timescale 1ns/1ps

module boot_loader_top
  #(parameter int fifo_depth_p = 4
   ,parameter int mem_words_p = 1024
   ,parameter int img_base_p = 256
   )
   (input  logic                                  clk_i
   ,input  logic                                  rst_i

   ,input  logic [boot_cfg_pkg::CORE_ID_W-1:0]    core_id_i

   ,input  logic                                  img_v_i
   ,input  logic [boot_cfg_pkg::DATA_W-1:0]       img_data_i
   ,input  logic                                  img_last_i
   ,output logic                                  img_ready_o

   ,input  logic                                  mem_rd_v_i
   ,input  logic [boot_cfg_pkg::ADDR_W-1:0]       mem_rd_addr_i
   ,output logic [boot_cfg_pkg::DATA_W-1:0]       mem_rd_data_o

   ,output logic                                  freeze_o
   ,output logic [boot_cfg_pkg::CORE_ID_W-1:0]    core_id_o
   ,output logic                                  done_o
   );

   import boot_cfg_pkg::*;
   import boot_msg_pkg::*;

   // sequencer to fifo
   logic             cmd_v;
   logic [OP_W-1:0]  cmd_op;
   boot_payload_u    cmd_payload;
   logic             cmd_ready;

   // fifo to target
   logic             fifo_v;
   logic [OP_W-1:0]  fifo_op;
   boot_payload_u    fifo_payload;
   logic             fifo_yumi;

   // target back to sequencer
   logic             resp_v;
   logic [OP_W-1:0]  resp_op;
   logic             resp_ready;

   boot_cmd_sequencer
     #(.fifo_depth_p(fifo_depth_p)
      ,.img_base_p(img_base_p)
      )
   seq_i
      (.clk_i(clk_i)
      ,.rst_i(rst_i)
      ,.core_id_i(core_id_i)
      ,.img_v_i(img_v_i)
      ,.img_data_i(img_data_i)
      ,.img_last_i(img_last_i)
      ,.img_ready_o(img_ready_o)
      ,.cmd_v_o(cmd_v)
      ,.cmd_op_o(cmd_op)
      ,.cmd_payload_o(cmd_payload)
      ,.cmd_ready_i(cmd_ready)
      ,.resp_v_i(resp_v)
      ,.resp_op_i(resp_op)
      ,.resp_ready_o(resp_ready)
      ,.done_o(done_o)
      );

   boot_cmd_fifo
     #(.fifo_depth_p(fifo_depth_p))
   fifo_i
      (.clk_i(clk_i)
      ,.rst_i(rst_i)
      ,.v_i(cmd_v)
      ,.op_i(cmd_op)
      ,.payload_i(cmd_payload)
      ,.ready_o(cmd_ready)
      ,.v_o(fifo_v)
      ,.op_o(fifo_op)
      ,.payload_o(fifo_payload)
      ,.yumi_i(fifo_yumi)
      );

   boot_mem_target
     #(.mem_words_p(mem_words_p))
   target_i
      (.clk_i(clk_i)
      ,.rst_i(rst_i)
      ,.cmd_v_i(fifo_v)
      ,.cmd_op_i(fifo_op)
      ,.cmd_payload_i(fifo_payload)
      ,.cmd_yumi_o(fifo_yumi)
      ,.resp_v_o(resp_v)
      ,.resp_op_o(resp_op)
      ,.resp_ready_i(resp_ready)
      ,.mem_rd_v_i(mem_rd_v_i)
      ,.mem_rd_addr_i(mem_rd_addr_i)
      ,.mem_rd_data_o(mem_rd_data_o)
      ,.freeze_o(freeze_o)
      ,.core_id_o(core_id_o)
      );

endmodule

/* verification/boot_tb.sv */
`timescale 1ns/1ps

module boot_tb;

   import boot_cfg_pkg::*;

   localparam int fifo_depth_lp = 4;
   localparam int mem_words_lp  = 1024;
   localparam int img_base_lp   = 256;
   localparam int max_len_lp    = 40;

   logic                 clk;
   logic                 rst;
   logic [CORE_ID_W-1:0] core_id;
   logic                 img_v;
   logic [DATA_W-1:0]    img_data;
   logic                 img_last;
   logic                 img_ready;
   logic                 rd_v;
   logic [ADDR_W-1:0]    rd_addr;
   logic [DATA_W-1:0]    rd_data;
   logic                 freeze;
   logic [CORE_ID_W-1:0] core_id_out;
   logic                 done;

   // expected image and core id
   logic [DATA_W-1:0]    model_mem [max_len_lp];
   logic [CORE_ID_W-1:0] exp_core_id;
   int                   img_len = 0;
   logic [31:0]          lfsr_state;

   boot_loader_top
     #(.fifo_depth_p(fifo_depth_lp)
      ,.mem_words_p(mem_words_lp)
      ,.img_base_p(img_base_lp)
      )
   boot_loader_top_i
      (.clk_i(clk)
      ,.rst_i(rst)
      ,.core_id_i(core_id)
      ,.img_v_i(img_v)
      ,.img_data_i(img_data)
      ,.img_last_i(img_last)
      ,.img_ready_o(img_ready)
      ,.mem_rd_v_i(rd_v)
      ,.mem_rd_addr_i(rd_addr)
      ,.mem_rd_data_o(rd_data)
      ,.freeze_o(freeze)
      ,.core_id_o(core_id_out)
      ,.done_o(done)
      );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // galois form, right shift
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      logic [31:0] n;
      n = s >> 1;
      if (s[0])
         n = n ^ 32'hd000_0001;
      return n;
   endfunction

   // one lfsr step per bit
   task automatic take_bits(input int count, output logic [31:0] bits);
      int b;
      bits = '0;
      for (b = 0; b < count; b++)
      begin
         bits[b] = lfsr_state[0];
         lfsr_state = lfsr_step(lfsr_state);
      end
   endtask

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected)
      begin
         $display("FAILED at time %0t: %s = 0x%08h, expected 0x%08h",
                  $time, name, actual, expected);
         $display("** FAIL **");
         $fatal(1, "value mismatch");
      end
   endtask

   initial
   begin
      wait (img_len > 0);
      repeat (20 * img_len + 200) @(posedge clk);
      $display("timeout: the image load did not finish within %0d cycles",
               20 * img_len + 200);
      $display("** FAIL **");
      $fatal(1, "watchdog expired");
   end

   initial
   begin
      logic [31:0] bits;
      int          accepted;
      int          i;

      lfsr_state = 32'h0ef15523;
      rst        = 1'b1;
      core_id    = '0;
      img_v      = 1'b0;
      img_data   = '0;
      img_last   = 1'b0;
      rd_v       = 1'b0;
      rd_addr    = '0;
      accepted   = 0;

      take_bits(6, bits);
      img_len = 8 + int'(bits % 32'd33);
      take_bits(4, bits);
      exp_core_id = bits[CORE_ID_W-1:0];
      for (i = 0; i < img_len; i++)
      begin
         take_bits(32, bits);
         model_mem[i] = bits;
      end
      core_id = exp_core_id;

      repeat (5) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      @(negedge clk);
      check_value("freeze_o", 32'(freeze), 32'd1);
      check_value("done_o", 32'(done), 32'd0);
      check_value("core_id_o", 32'(core_id_out), 32'd0);
      check_value("img_ready_o", 32'(img_ready), 32'd0);

      // ready only moves on posedge, so its negedge value holds for the transfer
      while (accepted < img_len)
      begin
         @(negedge clk);
         check_value("done_o", 32'(done), 32'd0);
         check_value("freeze_o", 32'(freeze), 32'd1);
         take_bits(1, bits);
         img_v    = bits[0];
         img_data = model_mem[accepted];
         img_last = (accepted == img_len - 1);
         if (img_v && img_ready)
            accepted++;
      end
      @(negedge clk);
      img_v    = 1'b0;
      img_last = 1'b0;
      img_data = '0;

      // core is released a couple of cycles before the drain ends
      while (done !== 1'b1)
      begin
         @(negedge clk);
         check_value("img_ready_o", 32'(img_ready), 32'd0);
      end
      check_value("freeze_o", 32'(freeze), 32'd0);
      check_value("core_id_o", 32'(core_id_out), 32'(exp_core_id));

      // back to back reads, data one cycle later
      for (i = 0; i < img_len; i++)
      begin
         rd_v    = 1'b1;
         rd_addr = ADDR_W'(img_base_lp + i);
         @(negedge clk);
         check_value("mem_rd_data_o", rd_data, model_mem[i]);
         check_value("done_o", 32'(done), 32'd1);
         check_value("freeze_o", 32'(freeze), 32'd0);
      end
      rd_v = 1'b0;

      repeat (4)
      begin
         @(negedge clk);
         check_value("done_o", 32'(done), 32'd1);
      end

      $display("** PASS **");
      $finish;
   end

endmodule

/* build.f */
hw/boot_cfg_pkg.sv
hw/boot_msg_pkg.sv
hw/boot_cmd_sequencer.sv
hw/boot_cmd_fifo.sv
hw/boot_mem_target.sv
hw/boot_loader_top.sv
verification/boot_tb.sv

/* Makefile */
# Verilator build and run of the boot loader testbench

TOP := boot_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing -f build.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -qxF '** PASS **' $(LOG); then \
		echo "test passed"; \
	else \
		echo "test failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
